// File: design/rvfi_trace_pkg.sv
//////////////////////////////////////////////////////////////////////
// Sizes are fixed here and shared by every block of the trace unit
// NMEM above 1 is assumed, lane masks are 4 bits wide per lane
//////////////////////////////////////////////////////////////////////
package rvfi_trace_pkg;

  // Memory lanes per retirement
  localparam int NMEM       = 2;
  // Instruction table entries
  localparam int ITB_DEPTH  = 16;
  // Retirements held in the queue
  localparam int FIFO_DEPTH = 4;
  // Function id width
  localparam int FUNC_W     = 8;

  // Derived widths
  localparam int LANE_W     = (NMEM > 1) ? $clog2(NMEM) : 1;
  localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int ITB_IDX_W  = (ITB_DEPTH > 1) ? $clog2(ITB_DEPTH) : 1;
  localparam int REC_CNT_W  = $clog2(NMEM + 1);

  typedef logic [LANE_W-1:0]     lane_t;
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;
  typedef logic [ITB_IDX_W-1:0]  itb_idx_t;
  typedef logic [REC_CNT_W-1:0]  rec_cnt_t;

  // One retired instruction as sampled from RVFI
  typedef struct packed {
    logic [31:0]        pc;
    logic [4:0]         rd_addr;
    logic [31:0]        rd_wdata;
    logic [32*NMEM-1:0] mem_addr;
    logic [4*NMEM-1:0]  mem_rmask;
    logic [4*NMEM-1:0]  mem_wmask;
    logic [32*NMEM-1:0] mem_rdata;
    logic [32*NMEM-1:0] mem_wdata;
  } retire_t;

  // One instruction table entry
  typedef struct packed {
    logic              valid;
    logic [31:0]       addr;
    logic [31:0]       mcode;
    logic [FUNC_W-1:0] func_id;
  } itb_entry_t;

  // Emitter FSM states
  typedef enum logic [0:0] {
    EMIT_IDLE,
    EMIT_LANES
  } emit_state_t;

endpackage

// File: design/itb_lookup_if.sv
//////////////////////////////////////////////////////////////////////
// PC lookup is combinational, result is valid in the same cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface itb_lookup_if;

  // Retired PC to look up
  logic [31:0]                       pc;

  // Lookup result
  logic                              hit;
  logic [31:0]                       mcode;
  logic [rvfi_trace_pkg::FUNC_W-1:0] func_id;

  // Emitter side, drives the PC
  modport requester (
    output pc,
    input  hit,
    input  mcode,
    input  func_id
  );

  // Table side, answers from the PC
  modport responder (
    input  pc,
    output hit,
    output mcode,
    output func_id
  );

endinterface

// File: design/rvfi_retire_fifo.sv
//////////////////////////////////////////////////////////////////////
// No back-pressure, a push into a full queue is lost and flagged
// Pop is only legal while empty is low
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvfi_retire_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    push,
  input  rvfi_trace_pkg::retire_t push_rec,
  input  logic                    pop,
  output rvfi_trace_pkg::retire_t head,
  output logic                    empty,
  output logic                    overflow
);

  // Storage
  rvfi_trace_pkg::retire_t   mem [rvfi_trace_pkg::FIFO_DEPTH];

  // Pointers and occupancy
  rvfi_trace_pkg::fifo_ptr_t wr_ptr;
  rvfi_trace_pkg::fifo_ptr_t rd_ptr;
  rvfi_trace_pkg::fifo_cnt_t count;

  logic full;
  logic do_push;
  logic do_pop;

  ////////////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////////////
  assign full  = (count == rvfi_trace_pkg::fifo_cnt_t'(rvfi_trace_pkg::FIFO_DEPTH));
  assign empty = (count == '0);

  assign do_pop  = pop && !empty;
  // A pop in the same cycle frees a slot for the new entry
  assign do_push = push && (!full || do_pop);

  ////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // Wrap pointers at the last slot
      if (do_push) begin
        if (wr_ptr == rvfi_trace_pkg::fifo_ptr_t'(rvfi_trace_pkg::FIFO_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_ptr == rvfi_trace_pkg::fifo_ptr_t'(rvfi_trace_pkg::FIFO_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // Occupancy follows push and pop
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Sticky until reset
      if (push && !do_push) begin
        overflow <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Data
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_rec;
    end
  end

  // Head is the oldest entry, undefined while empty
  assign head = mem[rd_ptr];

  // Emitter must wait for a retirement before popping
  a_no_pop_when_empty : assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> !empty
  ) else $error("retire queue popped while empty");

endmodule

// File: design/itb_map.sv
//////////////////////////////////////////////////////////////////////
// Loads overwrite a matching address first, else take the lowest free slot
// Once full, loads of new addresses are ignored until reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module itb_map (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              load_en,
  input  logic [31:0]                       load_addr,
  input  logic [31:0]                       load_mcode,
  input  logic [rvfi_trace_pkg::FUNC_W-1:0] load_func,
  itb_lookup_if.responder                   lookup,
  output logic                              full
);

  // Table registers
  rvfi_trace_pkg::itb_entry_t tbl [rvfi_trace_pkg::ITB_DEPTH];

  logic [rvfi_trace_pkg::ITB_DEPTH-1:0] valid_vec;
  logic [rvfi_trace_pkg::ITB_DEPTH-1:0] pc_match;

  // Load allocation
  logic                     match_hit;
  logic                     free_hit;
  rvfi_trace_pkg::itb_idx_t match_idx;
  rvfi_trace_pkg::itb_idx_t free_idx;
  rvfi_trace_pkg::itb_idx_t wr_idx;

  ////////////////////////////////////////////////////////////////////
  // Load slot search
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    match_hit = 1'b0;
    free_hit  = 1'b0;
    match_idx = '0;
    free_idx  = '0;
    // Descending scan so the lowest index wins
    for (int i = rvfi_trace_pkg::ITB_DEPTH - 1; i >= 0; i--) begin
      valid_vec[i] = tbl[i].valid;
      if (tbl[i].valid && (tbl[i].addr == load_addr)) begin
        match_hit = 1'b1;
        match_idx = rvfi_trace_pkg::itb_idx_t'(i);
      end
      if (!tbl[i].valid) begin
        free_hit = 1'b1;
        free_idx = rvfi_trace_pkg::itb_idx_t'(i);
      end
    end
  end

  // Existing entry takes priority over a free slot
  assign wr_idx = match_hit ? match_idx : free_idx;
  assign full   = &valid_vec;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Every entry starts empty
      for (int i = 0; i < rvfi_trace_pkg::ITB_DEPTH; i++) begin
        tbl[i].valid <= 1'b0;
      end
    end else if (load_en && (match_hit || free_hit)) begin
      tbl[wr_idx] <= '{valid: 1'b1, addr: load_addr, mcode: load_mcode, func_id: load_func};
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Associative lookup
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    lookup.hit     = 1'b0;
    lookup.mcode   = '0;
    lookup.func_id = '0;
    for (int i = 0; i < rvfi_trace_pkg::ITB_DEPTH; i++) begin
      pc_match[i] = tbl[i].valid && (tbl[i].addr == lookup.pc);
      if (pc_match[i]) begin
        lookup.hit     = 1'b1;
        lookup.mcode   = tbl[i].mcode;
        lookup.func_id = tbl[i].func_id;
      end
    end
  end

  // Loads never create two live entries for one address
  a_unique_match : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(lookup.pc) |-> $onehot0(pc_match)
  ) else $error("instruction table holds duplicate address");

endmodule

// File: design/trace_emitter.sv
//////////////////////////////////////////////////////////////////////
// One record per active lane in ascending order, or one when none is active
// Record fields are only meaningful while trace_valid is high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module trace_emitter (
  input  logic                              clk,
  input  logic                              rst_n,
  input  rvfi_trace_pkg::retire_t           head,
  input  logic                              empty,
  output logic                              pop,
  itb_lookup_if.requester                   lookup,
  output logic                              trace_valid,
  output logic                              trace_last,
  output logic [31:0]                       trace_pc,
  output logic [4:0]                        trace_rd_addr,
  output logic [31:0]                       trace_rd_wdata,
  output rvfi_trace_pkg::lane_t             trace_lane,
  output logic [31:0]                       trace_mem_addr,
  output logic [3:0]                        trace_mem_rmask,
  output logic [3:0]                        trace_mem_wmask,
  output logic [31:0]                       trace_mem_data,
  output logic                              trace_hit,
  output logic [31:0]                       trace_mcode,
  output logic [rvfi_trace_pkg::FUNC_W-1:0] trace_func
);

  rvfi_trace_pkg::emit_state_t state;
  rvfi_trace_pkg::emit_state_t state_nxt;

  // Latched retirement
  rvfi_trace_pkg::retire_t rec;

  // Lanes still to emit
  logic [rvfi_trace_pkg::NMEM-1:0] rem;
  logic [rvfi_trace_pkg::NMEM-1:0] rem_nxt;
  rvfi_trace_pkg::lane_t           cur_lane;

  // Records already sent for this retirement
  rvfi_trace_pkg::rec_cnt_t rec_cnt;

  logic load_rec;

  // Lane is active if it reads or writes anything
  function automatic logic [rvfi_trace_pkg::NMEM-1:0] active_lanes(
    input rvfi_trace_pkg::retire_t r
  );
    logic [rvfi_trace_pkg::NMEM-1:0] act;
    for (int i = 0; i < rvfi_trace_pkg::NMEM; i++) begin
      act[i] = (|r.mem_rmask[i*4 +: 4]) || (|r.mem_wmask[i*4 +: 4]);
    end
    return act;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Lane stepping
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    cur_lane = '0;
    // Lowest remaining lane, lane 0 when nothing is left
    for (int i = rvfi_trace_pkg::NMEM - 1; i >= 0; i--) begin
      if (rem[i]) begin
        cur_lane = rvfi_trace_pkg::lane_t'(i);
      end
    end
    for (int i = 0; i < rvfi_trace_pkg::NMEM; i++) begin
      rem_nxt[i] = rem[i] && (cur_lane != rvfi_trace_pkg::lane_t'(i));
    end
  end

  assign trace_valid = (state == rvfi_trace_pkg::EMIT_LANES);
  assign trace_last  = trace_valid && (rem_nxt == '0);

  // Take the next retirement when idle or on the final record
  assign load_rec = !empty && ((state == rvfi_trace_pkg::EMIT_IDLE) || trace_last);
  assign pop      = load_rec;

  ////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    if (load_rec) begin
      state_nxt = rvfi_trace_pkg::EMIT_LANES;
    end else if (trace_last) begin
      state_nxt = rvfi_trace_pkg::EMIT_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= rvfi_trace_pkg::EMIT_IDLE;
      rem     <= '0;
      rec_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (load_rec) begin
        rem     <= active_lanes(head);
        rec_cnt <= '0;
      end else if (trace_valid) begin
        rem     <= rem_nxt;
        rec_cnt <= rec_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_rec) begin
      rec <= head;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Record fields
  ////////////////////////////////////////////////////////////////////
  assign lookup.pc = rec.pc;

  assign trace_pc        = rec.pc;
  assign trace_rd_addr   = rec.rd_addr;
  assign trace_rd_wdata  = rec.rd_wdata;
  assign trace_lane      = cur_lane;
  assign trace_mem_addr  = rec.mem_addr[cur_lane*32 +: 32];
  assign trace_mem_rmask = rec.mem_rmask[cur_lane*4 +: 4];
  assign trace_mem_wmask = rec.mem_wmask[cur_lane*4 +: 4];
  // Write data wins when the lane writes
  assign trace_mem_data  = (|trace_mem_wmask) ? rec.mem_wdata[cur_lane*32 +: 32]
                                              : rec.mem_rdata[cur_lane*32 +: 32];
  assign trace_hit       = lookup.hit;
  assign trace_mcode     = lookup.mcode;
  assign trace_func      = lookup.func_id;

  // Lane stepping ends within NMEM records
  a_max_records : assert property (
    @(posedge clk) disable iff (!rst_n) trace_valid |-> (rec_cnt < rvfi_trace_pkg::NMEM)
  ) else $error("more trace records than memory lanes for one retirement");

endmodule

// File: design/rvfi_trace_top.sv
//////////////////////////////////////////////////////////////////////
// No output back-pressure, check overflow for lost retirements
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvfi_trace_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // RVFI retirement
  input  logic                                   rvfi_valid,
  input  logic [31:0]                            rvfi_pc_rdata,
  input  logic [4:0]                             rvfi_rd_addr,
  input  logic [31:0]                            rvfi_rd_wdata,
  input  logic [32*rvfi_trace_pkg::NMEM-1:0]     rvfi_mem_addr,
  input  logic [4*rvfi_trace_pkg::NMEM-1:0]      rvfi_mem_rmask,
  input  logic [4*rvfi_trace_pkg::NMEM-1:0]      rvfi_mem_wmask,
  input  logic [32*rvfi_trace_pkg::NMEM-1:0]     rvfi_mem_rdata,
  input  logic [32*rvfi_trace_pkg::NMEM-1:0]     rvfi_mem_wdata,
  // Instruction table load
  input  logic                                   itb_load_en,
  input  logic [31:0]                            itb_load_addr,
  input  logic [31:0]                            itb_load_mcode,
  input  logic [rvfi_trace_pkg::FUNC_W-1:0]      itb_load_func,
  // Trace records
  output logic                                   trace_valid,
  output logic                                   trace_last,
  output logic [31:0]                            trace_pc,
  output logic [4:0]                             trace_rd_addr,
  output logic [31:0]                            trace_rd_wdata,
  output rvfi_trace_pkg::lane_t                  trace_lane,
  output logic [31:0]                            trace_mem_addr,
  output logic [3:0]                             trace_mem_rmask,
  output logic [3:0]                             trace_mem_wmask,
  output logic [31:0]                            trace_mem_data,
  output logic                                   trace_hit,
  output logic [31:0]                            trace_mcode,
  output logic [rvfi_trace_pkg::FUNC_W-1:0]      trace_func,
  // Status
  output logic                                   overflow,
  output logic                                   itb_full
);

  rvfi_trace_pkg::retire_t push_rec;
  rvfi_trace_pkg::retire_t head;
  logic                    empty;
  logic                    pop;

  itb_lookup_if lookup_if ();

  // Pack the flat RVFI fields
  always_comb begin
    push_rec.pc        = rvfi_pc_rdata;
    push_rec.rd_addr   = rvfi_rd_addr;
    push_rec.rd_wdata  = rvfi_rd_wdata;
    push_rec.mem_addr  = rvfi_mem_addr;
    push_rec.mem_rmask = rvfi_mem_rmask;
    push_rec.mem_wmask = rvfi_mem_wmask;
    push_rec.mem_rdata = rvfi_mem_rdata;
    push_rec.mem_wdata = rvfi_mem_wdata;
  end

  rvfi_retire_fifo rvfi_retire_fifo_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (rvfi_valid),
    .push_rec (push_rec),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .overflow (overflow)
  );

  itb_map itb_map_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_en    (itb_load_en),
    .load_addr  (itb_load_addr),
    .load_mcode (itb_load_mcode),
    .load_func  (itb_load_func),
    .lookup     (lookup_if.responder),
    .full       (itb_full)
  );

  trace_emitter trace_emitter_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .head            (head),
    .empty           (empty),
    .pop             (pop),
    .lookup          (lookup_if.requester),
    .trace_valid     (trace_valid),
    .trace_last      (trace_last),
    .trace_pc        (trace_pc),
    .trace_rd_addr   (trace_rd_addr),
    .trace_rd_wdata  (trace_rd_wdata),
    .trace_lane      (trace_lane),
    .trace_mem_addr  (trace_mem_addr),
    .trace_mem_rmask (trace_mem_rmask),
    .trace_mem_wmask (trace_mem_wmask),
    .trace_mem_data  (trace_mem_data),
    .trace_hit       (trace_hit),
    .trace_mcode     (trace_mcode),
    .trace_func      (trace_func)
  );

endmodule

// File: bench/rvfi_trace_tb.sv
//////////////////////////////////////////////////////////////////////
// Cycle model of queue, emitter and table, checked by assertions
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvfi_trace_tb;

  // Expected trace record
  typedef struct packed {
    logic [31:0]           pc;
    logic [4:0]            rd_addr;
    logic [31:0]           rd_wdata;
    rvfi_trace_pkg::lane_t lane;
    logic [31:0]           addr;
    logic [3:0]            rmask;
    logic [3:0]            wmask;
    logic [31:0]           data;
    logic                  last;
  } exp_rec_t;

  logic                                   clk;
  logic                                   rst_n;
  logic                                   rvfi_valid;
  logic [31:0]                            rvfi_pc_rdata;
  logic [4:0]                             rvfi_rd_addr;
  logic [31:0]                            rvfi_rd_wdata;
  logic [32*rvfi_trace_pkg::NMEM-1:0]     rvfi_mem_addr;
  logic [4*rvfi_trace_pkg::NMEM-1:0]      rvfi_mem_rmask;
  logic [4*rvfi_trace_pkg::NMEM-1:0]      rvfi_mem_wmask;
  logic [32*rvfi_trace_pkg::NMEM-1:0]     rvfi_mem_rdata;
  logic [32*rvfi_trace_pkg::NMEM-1:0]     rvfi_mem_wdata;
  logic                                   itb_load_en;
  logic [31:0]                            itb_load_addr;
  logic [31:0]                            itb_load_mcode;
  logic [rvfi_trace_pkg::FUNC_W-1:0]      itb_load_func;
  logic                                   trace_valid;
  logic                                   trace_last;
  logic [31:0]                            trace_pc;
  logic [4:0]                             trace_rd_addr;
  logic [31:0]                            trace_rd_wdata;
  rvfi_trace_pkg::lane_t                  trace_lane;
  logic [31:0]                            trace_mem_addr;
  logic [3:0]                             trace_mem_rmask;
  logic [3:0]                             trace_mem_wmask;
  logic [31:0]                            trace_mem_data;
  logic                                   trace_hit;
  logic [31:0]                            trace_mcode;
  logic [rvfi_trace_pkg::FUNC_W-1:0]      trace_func;
  logic                                   overflow;
  logic                                   itb_full;

  // Model state
  exp_rec_t exp_q [$];
  int       k_q [$];
  int       mrem;
  logic     pop_m;
  logic     accept;
  exp_rec_t exp_cur;
  logic     exp_valid;
  logic     exp_overflow;
  logic     exp_full;
  logic     exp_hit;
  logic [31:0]                          exp_mcode;
  logic [rvfi_trace_pkg::FUNC_W-1:0]    exp_func;
  logic [rvfi_trace_pkg::ITB_DEPTH-1:0] mtbl_valid;
  logic [31:0]                          mtbl_addr [rvfi_trace_pkg::ITB_DEPTH];
  logic [31:0]                          mtbl_mcode [rvfi_trace_pkg::ITB_DEPTH];
  logic [rvfi_trace_pkg::FUNC_W-1:0]    mtbl_func [rvfi_trace_pkg::ITB_DEPTH];

  logic [31:0] lcg_state;
  int err_timing;
  int err_record;
  int err_lookup;
  int err_status;
  int err_other;

  rvfi_trace_top rvfi_trace_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////
  // Records of the sampled retirement, one per active lane
  function automatic int add_records();
    exp_rec_t recs [rvfi_trace_pkg::NMEM];
    exp_rec_t r;
    int       n;
    n = 0;
    for (int i = 0; i < rvfi_trace_pkg::NMEM; i++) begin
      r.pc       = rvfi_pc_rdata;
      r.rd_addr  = rvfi_rd_addr;
      r.rd_wdata = rvfi_rd_wdata;
      r.lane     = rvfi_trace_pkg::lane_t'(i);
      r.addr     = rvfi_mem_addr[i*32 +: 32];
      r.rmask    = rvfi_mem_rmask[i*4 +: 4];
      r.wmask    = rvfi_mem_wmask[i*4 +: 4];
      r.data     = (r.wmask != 0) ? rvfi_mem_wdata[i*32 +: 32] : rvfi_mem_rdata[i*32 +: 32];
      r.last     = 1'b0;
      if ((r.rmask != 0) || (r.wmask != 0)) begin
        recs[n] = r;
        n++;
      end
    end
    // No active lane at all, lane 0 stands in
    if (n == 0) begin
      r.lane     = '0;
      r.addr     = rvfi_mem_addr[31:0];
      r.rmask    = '0;
      r.wmask    = '0;
      r.data     = rvfi_mem_rdata[31:0];
      recs[0]    = r;
      n          = 1;
    end
    recs[n-1].last = 1'b1;
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(recs[i]);
    end
    return n;
  endfunction

  // Overwrite a matching address, else lowest free slot, else ignore
  function automatic void model_load(input logic [31:0] a, input logic [31:0] mc,
                                     input logic [rvfi_trace_pkg::FUNC_W-1:0] f);
    int slot;
    slot = -1;
    for (int i = 0; i < rvfi_trace_pkg::ITB_DEPTH; i++) begin
      if (mtbl_valid[i] && (mtbl_addr[i] == a) && (slot < 0)) slot = i;
    end
    for (int i = 0; i < rvfi_trace_pkg::ITB_DEPTH; i++) begin
      if (!mtbl_valid[i] && (slot < 0)) slot = i;
    end
    if (slot >= 0) begin
      mtbl_valid[slot] = 1'b1;
      mtbl_addr[slot]  = a;
      mtbl_mcode[slot] = mc;
      mtbl_func[slot]  = f;
    end
  endfunction

  function automatic void model_lookup(input logic [31:0] pc);
    exp_hit   = 1'b0;
    exp_mcode = '0;
    exp_func  = '0;
    for (int i = 0; i < rvfi_trace_pkg::ITB_DEPTH; i++) begin
      if (mtbl_valid[i] && (mtbl_addr[i] == pc)) begin
        exp_hit   = 1'b1;
        exp_mcode = mtbl_mcode[i];
        exp_func  = mtbl_func[i];
      end
    end
  endfunction

  // Samples the same pre-edge values as the DUT
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q.delete();
      k_q.delete();
      mrem         = 0;
      exp_valid    = 1'b0;
      exp_overflow = 1'b0;
      exp_full     = 1'b0;
      mtbl_valid   = '0;
      model_lookup(32'h0);
    end else begin
      // Pop when idle or on the last record, push may reuse that slot
      pop_m  = (k_q.size() > 0) && (mrem <= 1);
      accept = rvfi_valid && ((k_q.size() < rvfi_trace_pkg::FIFO_DEPTH) || pop_m);
      if (rvfi_valid && !accept) exp_overflow = 1'b1;
      if (mrem > 0) begin
        void'(exp_q.pop_front());
        mrem--;
      end
      if (pop_m) mrem = k_q.pop_front();
      if (accept) k_q.push_back(add_records());
      if (itb_load_en) model_load(itb_load_addr, itb_load_mcode, itb_load_func);
      exp_full  = &mtbl_valid;
      exp_valid = (mrem > 0);
      if (exp_valid) exp_cur = exp_q[0];
      model_lookup(exp_cur.pc);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////
  a_reset_state : assert property (
    @(posedge clk) $rose(rst_n) |-> !trace_valid && !trace_last && !overflow && !itb_full
  ) else begin
    err_status++;
    $display("ERROR %0t: outputs not low after reset", $time);
  end

  a_valid_timing : assert property (
    @(posedge clk) disable iff (!rst_n) trace_valid == exp_valid
  ) else begin
    err_timing++;
    $display("ERROR %0t: trace_valid is %b, expected %b", $time,
             $sampled(trace_valid), $sampled(exp_valid));
  end

  a_record : assert property (
    @(posedge clk) disable iff (!rst_n) trace_valid && exp_valid |->
      trace_pc == exp_cur.pc && trace_rd_addr == exp_cur.rd_addr &&
      trace_rd_wdata == exp_cur.rd_wdata && trace_lane == exp_cur.lane &&
      trace_mem_addr == exp_cur.addr && trace_mem_rmask == exp_cur.rmask &&
      trace_mem_wmask == exp_cur.wmask && trace_mem_data == exp_cur.data &&
      trace_last == exp_cur.last
  ) else begin
    err_record++;
    $display("ERROR %0t: record mismatch at pc %h lane %0d", $time,
             $sampled(trace_pc), $sampled(trace_lane));
  end

  a_lookup : assert property (
    @(posedge clk) disable iff (!rst_n) trace_valid && exp_valid |->
      trace_hit == exp_hit && trace_mcode == exp_mcode && trace_func == exp_func
  ) else begin
    err_lookup++;
    $display("ERROR %0t: table lookup mismatch for pc %h", $time, $sampled(trace_pc));
  end

  a_status : assert property (
    @(posedge clk) disable iff (!rst_n) overflow == exp_overflow && itb_full == exp_full
  ) else begin
    err_status++;
    $display("ERROR %0t: overflow %b itb_full %b, expected %b %b", $time,
             $sampled(overflow), $sampled(itb_full), $sampled(exp_overflow),
             $sampled(exp_full));
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////
  task automatic send_retire(input logic [31:0] pc,
                             input logic [4*rvfi_trace_pkg::NMEM-1:0] rmask,
                             input logic [4*rvfi_trace_pkg::NMEM-1:0] wmask);
    logic [31:0]                        r;
    logic [32*rvfi_trace_pkg::NMEM-1:0] addr_v;
    logic [32*rvfi_trace_pkg::NMEM-1:0] rdata_v;
    logic [32*rvfi_trace_pkg::NMEM-1:0] wdata_v;
    for (int i = 0; i < rvfi_trace_pkg::NMEM; i++) begin
      addr_v[i*32 +: 32]  = lcg_next();
      rdata_v[i*32 +: 32] = lcg_next();
      wdata_v[i*32 +: 32] = lcg_next();
    end
    r = lcg_next();
    @(posedge clk);
    rvfi_valid     <= 1'b1;
    rvfi_pc_rdata  <= pc;
    rvfi_rd_addr   <= r[20:16];
    rvfi_rd_wdata  <= lcg_next();
    rvfi_mem_addr  <= addr_v;
    rvfi_mem_rmask <= rmask;
    rvfi_mem_wmask <= wmask;
    rvfi_mem_rdata <= rdata_v;
    rvfi_mem_wdata <= wdata_v;
  endtask

  // Random masks, PCs spread over loaded and unloaded addresses
  task automatic send_random(input logic all_active);
    logic [31:0]                       r;
    logic [4*rvfi_trace_pkg::NMEM-1:0] rm;
    logic [4*rvfi_trace_pkg::NMEM-1:0] wm;
    for (int i = 0; i < rvfi_trace_pkg::NMEM; i++) begin
      r = lcg_next();
      rm[i*4 +: 4] = r[31] ? r[27:24] : 4'h0;
      wm[i*4 +: 4] = r[30] ? r[23:20] : 4'h0;
      if (all_active && (rm[i*4 +: 4] == 0) && (wm[i*4 +: 4] == 0)) wm[i*4 +: 4] = 4'hf;
    end
    r = lcg_next();
    send_retire(32'h1000 + {27'h0, r[27:25], 2'b00}, rm, wm);
  endtask

  task automatic stop_retire();
    @(posedge clk);
    rvfi_valid <= 1'b0;
  endtask

  task automatic load_itb(input logic [31:0] addr, input logic [31:0] mcode,
                          input logic [rvfi_trace_pkg::FUNC_W-1:0] func);
    @(posedge clk);
    itb_load_en    <= 1'b1;
    itb_load_addr  <= addr;
    itb_load_mcode <= mcode;
    itb_load_func  <= func;
    @(posedge clk);
    itb_load_en    <= 1'b0;
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (((exp_q.size() != 0) || trace_valid) && (n < limit));
    if ((exp_q.size() != 0) || trace_valid) begin
      err_other++;
      $display("Timed out waiting for the trace records to drain");
    end
  endtask

  initial begin
    lcg_state      = 32'd52551;
    err_timing     = 0;
    err_record     = 0;
    err_lookup     = 0;
    err_status     = 0;
    err_other      = 0;
    rst_n          = 1'b0;
    rvfi_valid     = 1'b0;
    rvfi_pc_rdata  = '0;
    rvfi_rd_addr   = '0;
    rvfi_rd_wdata  = '0;
    rvfi_mem_addr  = '0;
    rvfi_mem_rmask = '0;
    rvfi_mem_wmask = '0;
    rvfi_mem_rdata = '0;
    rvfi_mem_wdata = '0;
    itb_load_en    = 1'b0;
    itb_load_addr  = '0;
    itb_load_mcode = '0;
    itb_load_func  = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Retirement without memory access
    send_retire(32'h100, '0, '0);
    stop_retire();
    wait_drained(50);

    // Half of the random PCs hit the table
    for (int i = 0; i < 4; i++) begin
      load_itb(32'h1000 + 32'(i * 4), lcg_next(), rvfi_trace_pkg::FUNC_W'(i + 1));
    end
    repeat (24) begin
      send_random(1'b0);
      stop_retire();
      wait_drained(50);
    end

    // Reload replaces the stored values
    load_itb(32'h1000, 32'hdeadbeef, 8'h5a);
    send_retire(32'h1000, 8'h0f, 8'h00);
    stop_retire();
    wait_drained(50);

    // Back to back within queue depth
    repeat (rvfi_trace_pkg::FIFO_DEPTH) send_random(1'b0);
    stop_retire();
    wait_drained(100);

    // Burst past the queue depth
    repeat (10) send_random(1'b1);
    stop_retire();
    wait_drained(200);
    if (!exp_overflow) begin
      err_other++;
      $display("Burst did not overflow the retirement queue");
    end

    // Fill the table, one extra load is ignored
    for (int i = 4; i < rvfi_trace_pkg::ITB_DEPTH; i++) begin
      load_itb(32'h2000 + 32'(i * 4), lcg_next(), rvfi_trace_pkg::FUNC_W'(i + 1));
    end
    load_itb(32'h3000, 32'h12345678, 8'hff);
    if (!exp_full) begin
      err_other++;
      $display("Instruction table did not fill up");
    end
    send_retire(32'h3000, 8'h00, 8'h30);
    send_retire(32'h2010, 8'h11, 8'h00);
    stop_retire();
    wait_drained(100);

    $display("Error counts: timing %0d, record %0d, lookup %0d, status %0d, other %0d",
             err_timing, err_record, err_lookup, err_status, err_other);
    if ((err_timing + err_record + err_lookup + err_status + err_other) == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: files.f
design/rvfi_trace_pkg.sv
design/itb_lookup_if.sv
design/rvfi_retire_fifo.sv
design/itb_map.sv
design/trace_emitter.sv
design/rvfi_trace_top.sv
bench/rvfi_trace_tb.sv
